//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = tb_dma_resp_unit
FILELIST   = sim.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/dma_done_tracker.sv
`timescale 1ns/10ps

module dma_done_tracker (
  input  logic                             clk,
  input  logic                             rst,

  input  logic                             add_i,
  input  logic                             clear_i,
  input  logic [dma_pkg::TABLE_PTR_W-1:0]  id_i,

  output logic [dma_pkg::COUNT_W-1:0]      count_o
);

  ////////////////////////////////////////
  // Word counters per table entry
  ////////////////////////////////////////

  logic [dma_pkg::COUNT_W-1:0] cnt_q [dma_pkg::TABLE_ENTRIES];

  // Includes a same-cycle add
  // so the last data flit shows up in the completion
  assign count_o = cnt_q[id_i] + dma_pkg::COUNT_W'(add_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < dma_pkg::TABLE_ENTRIES; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      // Clear wins over add since the count already went out
      if (clear_i) begin
        cnt_q[id_i] <= '0;
      end else if (add_i) begin
        cnt_q[id_i] <= count_o;
      end
    end
  end

endmodule

//--- hdl/dma_mem_writer.sv
`timescale 1ns/10ps

module dma_mem_writer (
  input  logic                        clk,
  input  logic                        rst,

  input  logic                        load_i,
  input  logic                        write_i,
  input  logic [dma_pkg::DATA_W-1:0]  word_i,

  output logic [dma_pkg::DATA_W-1:0]  next_addr_o,
  output dma_pkg::bus_wr_t            bus_o
);

  ////////////////////////////////////////
  // Running word address
  ////////////////////////////////////////

  logic [dma_pkg::DATA_W-1:0] addr_q;
  dma_pkg::bus_wr_t           bus_q;

  // Address after this cycle as seen by the sequencer
  // so a same-cycle load or write is included
  assign next_addr_o = load_i  ? word_i :
                       write_i ? addr_q + 1'b1 :
                                 addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q   <= '0;
      bus_q.en <= 1'b0;
    end else begin
      addr_q   <= next_addr_o;
      // Enable only in the cycle after a write strobe
      bus_q.en <= write_i;
      if (write_i) begin
        bus_q.addr <= addr_q;
        bus_q.data <= word_i;
      end
    end
  end

  assign bus_o = bus_q;

endmodule

//--- hdl/dma_packet_buffer.sv
`timescale 1ns/10ps

module dma_packet_buffer (
  input  logic           clk,
  input  logic           rst,

  input  dma_pkg::flit_t in_flit_i,
  input  logic           in_valid_i,
  output logic           in_ready_o,

  output dma_pkg::flit_t out_flit_o,
  output logic           out_valid_o,
  input  logic           out_ready_i
);

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////

  dma_pkg::flit_t                     mem [dma_pkg::FIFO_DEPTH];
  logic [dma_pkg::FIFO_PTR_W-1:0]     wr_ptr;
  logic [dma_pkg::FIFO_PTR_W-1:0]     rd_ptr;
  logic [dma_pkg::FIFO_CNT_W-1:0]     count;

  logic push;
  logic pop;

  // Full only at FIFO_DEPTH entries
  assign in_ready_o  = (count != dma_pkg::FIFO_CNT_W'(dma_pkg::FIFO_DEPTH));
  assign out_valid_o = (count != '0);
  assign out_flit_o  = mem[rd_ptr];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // Flit array
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit_i;
    end
  end

  // Pointers wrap since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- hdl/dma_pkg.sv
package dma_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Transfer table
  localparam int TABLE_ENTRIES = 4;
  localparam int TABLE_PTR_W   = $clog2(TABLE_ENTRIES);

  // Flit content, bus word and address width
  localparam int DATA_W = 32;

  // Packet buffer
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Received words per table entry
  localparam int COUNT_W = 8;

  ////////////////////////////////////////
  // Flit encoding
  ////////////////////////////////////////

  // Flit marker where LAST or SINGLE closes a packet
  typedef enum logic [1:0] {
    FLIT_NORMAL = 2'b00,
    FLIT_RSVD   = 2'b01,
    FLIT_LAST   = 2'b10,
    FLIT_SINGLE = 2'b11
  } flit_type_e;

  // Packet type in the header with other codes unknown
  typedef enum logic [1:0] {
    PKT_L2R_RESP = 2'b01,
    PKT_R2L_RESP = 2'b10
  } pkt_type_e;

  // Header view of the flit content
  typedef struct packed {
    pkt_type_e                   pkt_type;
    logic                        resp_last;
    logic [TABLE_PTR_W-1:0]      id;
    logic [DATA_W-TABLE_PTR_W-4:0] rsvd;
  } resp_hdr_t;

  // Header or plain address/data word
  typedef union packed {
    resp_hdr_t          hdr;
    logic [DATA_W-1:0]  word;
  } flit_content_u;

  typedef struct packed {
    flit_type_e    ftype;
    flit_content_u content;
  } flit_t;

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // One strobe bus write
  typedef struct packed {
    logic              en;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } bus_wr_t;

  // Completion of one table entry
  typedef struct packed {
    logic                   valid;
    logic [TABLE_PTR_W-1:0] id;
    logic [COUNT_W-1:0]     count;
    logic [DATA_W-1:0]      end_addr;
  } done_rec_t;

endpackage

//--- hdl/dma_resp_sequencer.sv
`timescale 1ns/10ps

module dma_resp_sequencer (
  input  logic                             clk,
  input  logic                             rst,

  input  dma_pkg::flit_t                   flit_i,
  input  logic                             flit_valid_i,
  output logic                             flit_ready_o,

  output logic                             wr_load_o,
  output logic                             wr_write_o,
  output logic [dma_pkg::DATA_W-1:0]       wr_word_o,
  input  logic [dma_pkg::DATA_W-1:0]       wr_next_addr_i,

  output logic                             trk_add_o,
  output logic                             trk_clear_o,
  output logic [dma_pkg::TABLE_PTR_W-1:0]  trk_id_o,
  input  logic [dma_pkg::COUNT_W-1:0]      trk_count_i,

  output dma_pkg::done_rec_t               done_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_GET_SIZE,
    ST_GET_ADDR,
    ST_DATA,
    ST_DROP
  } state_e;

  state_e                            state_q;
  state_e                            state_d;
  logic [dma_pkg::TABLE_PTR_W-1:0]   id_q;
  logic [dma_pkg::TABLE_PTR_W-1:0]   id_d;
  logic                              last_q;
  logic                              last_d;
  dma_pkg::resp_hdr_t                hdr;
  dma_pkg::done_rec_t                done_q;
  logic                              pop;
  logic                              flit_end;
  logic                              finish;
  logic                              l2r_no_data;

  ////////////////////////////////////////
  // Flit decode
  ////////////////////////////////////////

  // Always ready since writer and tracker never stall
  assign flit_ready_o = 1'b1;
  assign pop          = flit_valid_i & flit_ready_o;
  assign flit_end     = (flit_i.ftype == dma_pkg::FLIT_LAST) ||
                        (flit_i.ftype == dma_pkg::FLIT_SINGLE);
  // Header view is only meaningful in idle
  assign hdr          = flit_i.content.hdr;
  // Address and data through the word view
  assign wr_word_o    = flit_i.content.word;

  // Header id before it is latched
  assign trk_id_o     = (state_q == ST_IDLE) ? hdr.id : id_q;
  assign trk_clear_o  = finish;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    id_d       = id_q;
    last_d     = last_q;
    wr_load_o  = 1'b0;
    wr_write_o = 1'b0;
    trk_add_o  = 1'b0;
    finish     = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (pop) begin
          id_d   = hdr.id;
          last_d = hdr.resp_last;
          if (hdr.pkt_type == dma_pkg::PKT_L2R_RESP && flit_end) begin
            // Single flit L2R completion
            finish = hdr.resp_last;
          end else if (hdr.pkt_type == dma_pkg::PKT_R2L_RESP && !flit_end) begin
            state_d = ST_GET_SIZE;
          end else if (!flit_end) begin
            // Unknown or malformed packet
            state_d = ST_DROP;
          end
        end
      end
      ST_GET_SIZE: begin
        // Size flit discarded
        if (pop) begin
          finish  = flit_end & last_q;
          state_d = flit_end ? ST_IDLE : ST_GET_ADDR;
        end
      end
      ST_GET_ADDR: begin
        if (pop) begin
          wr_load_o = 1'b1;
          finish    = flit_end & last_q;
          state_d   = flit_end ? ST_IDLE : ST_DATA;
        end
      end
      ST_DATA: begin
        // One bus write and one count per data flit
        if (pop) begin
          wr_write_o = 1'b1;
          trk_add_o  = 1'b1;
          finish     = flit_end & last_q;
          if (flit_end) begin
            state_d = ST_IDLE;
          end
        end
      end
      ST_DROP: begin
        if (pop && flit_end) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // L2R entry without data reports address 0
  assign l2r_no_data = (state_q == ST_IDLE) && (trk_count_i == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= ST_IDLE;
      id_q         <= '0;
      last_q       <= 1'b0;
      done_q.valid <= 1'b0;
    end else begin
      state_q      <= state_d;
      id_q         <= id_d;
      last_q       <= last_d;
      // One cycle completion pulse
      done_q.valid <= finish;
      if (finish) begin
        done_q.id       <= trk_id_o;
        done_q.count    <= trk_count_i;
        done_q.end_addr <= l2r_no_data ? '0 : wr_next_addr_i;
      end
    end
  end

  assign done_o = done_q;

endmodule

//--- hdl/dma_resp_unit.sv
`timescale 1ns/10ps

module dma_resp_unit (
  input  logic               clk,
  input  logic               rst,

  input  dma_pkg::flit_t     noc_flit_i,
  input  logic               noc_valid_i,
  output logic               noc_ready_o,

  output dma_pkg::bus_wr_t   bus_o,
  output dma_pkg::done_rec_t done_o
);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  // Buffer to sequencer
  dma_pkg::flit_t                    buf_flit;
  logic                              buf_valid;
  logic                              buf_ready;

  // Sequencer to writer
  logic                              wr_load;
  logic                              wr_write;
  logic [dma_pkg::DATA_W-1:0]        wr_word;
  logic [dma_pkg::DATA_W-1:0]        wr_next_addr;

  // Sequencer to tracker
  logic                              trk_add;
  logic                              trk_clear;
  logic [dma_pkg::TABLE_PTR_W-1:0]   trk_id;
  logic [dma_pkg::COUNT_W-1:0]       trk_count;

  dma_packet_buffer u_dma_packet_buffer (
    .clk         (clk),
    .rst         (rst),
    .in_flit_i   (noc_flit_i),
    .in_valid_i  (noc_valid_i),
    .in_ready_o  (noc_ready_o),
    .out_flit_o  (buf_flit),
    .out_valid_o (buf_valid),
    .out_ready_i (buf_ready)
  );

  dma_resp_sequencer u_dma_resp_sequencer (
    .clk            (clk),
    .rst            (rst),
    .flit_i         (buf_flit),
    .flit_valid_i   (buf_valid),
    .flit_ready_o   (buf_ready),
    .wr_load_o      (wr_load),
    .wr_write_o     (wr_write),
    .wr_word_o      (wr_word),
    .wr_next_addr_i (wr_next_addr),
    .trk_add_o      (trk_add),
    .trk_clear_o    (trk_clear),
    .trk_id_o       (trk_id),
    .trk_count_i    (trk_count),
    .done_o         (done_o)
  );

  // Owns the strobe bus
  dma_mem_writer u_dma_mem_writer (
    .clk         (clk),
    .rst         (rst),
    .load_i      (wr_load),
    .write_i     (wr_write),
    .word_i      (wr_word),
    .next_addr_o (wr_next_addr),
    .bus_o       (bus_o)
  );

  dma_done_tracker u_dma_done_tracker (
    .clk     (clk),
    .rst     (rst),
    .add_i   (trk_add),
    .clear_i (trk_clear),
    .id_i    (trk_id),
    .count_o (trk_count)
  );

endmodule

//--- sim.f
hdl/dma_pkg.sv
hdl/dma_packet_buffer.sv
hdl/dma_resp_sequencer.sv
hdl/dma_mem_writer.sv
hdl/dma_done_tracker.sv
hdl/dma_resp_unit.sv
test/dma_resp_unit_properties.sv
test/tb_dma_resp_unit.sv

//--- test/dma_resp_unit_properties.sv
`timescale 1ns/10ps

module dma_resp_unit_properties (
  input logic               clk,
  input logic               rst,
  input logic               noc_valid_i,
  input logic               noc_ready_i,
  input dma_pkg::flit_t     buf_flit_i,
  input logic               buf_valid_i,
  input logic               buf_ready_i,
  input dma_pkg::bus_wr_t   bus_i,
  input dma_pkg::done_rec_t done_i
);

  ////////////////////////////////////////
  // Own count of buffered flits
  ////////////////////////////////////////

  logic [dma_pkg::FIFO_CNT_W-1:0] outstanding;
  logic                           accepted;
  logic                           popped;
  logic                           end_popped;

  assign accepted   = noc_valid_i & noc_ready_i;
  assign popped     = buf_valid_i & buf_ready_i;
  // Pop of a LAST or SINGLE flit
  assign end_popped = popped && ((buf_flit_i.ftype == dma_pkg::FLIT_LAST) ||
                                 (buf_flit_i.ftype == dma_pkg::FLIT_SINGLE));

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + dma_pkg::FIFO_CNT_W'(accepted)
                                 - dma_pkg::FIFO_CNT_W'(popped);
    end
  end

  // Each valid cycle belongs to one packet end
  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done_i.valid |-> $past(end_popped))
    else $error("done_o valid without a packet end in the cycle before");

  a_reset_quiet: assert property (@(posedge clk)
    $fell(rst) |-> (!bus_i.en && !done_i.valid))
    else $error("bus or done output active right after reset");

  a_ready_full: assert property (@(posedge clk) disable iff (rst)
    !noc_ready_i |-> (outstanding == dma_pkg::FIFO_CNT_W'(dma_pkg::FIFO_DEPTH)))
    else $error("noc_ready_o low while the buffer is not full");

endmodule

bind dma_resp_unit dma_resp_unit_properties u_dma_resp_unit_properties (
  .clk         (clk),
  .rst         (rst),
  .noc_valid_i (noc_valid_i),
  .noc_ready_i (noc_ready_o),
  .buf_flit_i  (buf_flit),
  .buf_valid_i (buf_valid),
  .buf_ready_i (buf_ready),
  .bus_i       (bus_o),
  .done_i      (done_o)
);

//--- test/tb_dma_resp_unit.sv
`timescale 1ns/10ps

module tb_dma_resp_unit;

  logic               clk;
  logic               rst;
  dma_pkg::flit_t     noc_flit_i;
  logic               noc_valid_i;
  logic               noc_ready_o;
  dma_pkg::bus_wr_t   bus_o;
  dma_pkg::done_rec_t done_o;

  // Stimulus and reference model
  dma_pkg::flit_t     flits[$];
  dma_pkg::bus_wr_t   exp_wr[$];
  dma_pkg::done_rec_t exp_done[$];
  int unsigned        pending[dma_pkg::TABLE_ENTRIES];
  logic [31:0]        model_addr;
  int unsigned        burst_start;
  int unsigned        cycles;
  int unsigned        limit;

  dma_resp_unit u_dma_resp_unit (
    .clk         (clk),
    .rst         (rst),
    .noc_flit_i  (noc_flit_i),
    .noc_valid_i (noc_valid_i),
    .noc_ready_o (noc_ready_o),
    .bus_o       (bus_o),
    .done_o      (done_o)
  );

  // 100 ns period
  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Failure and stimulus helpers
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  function automatic dma_pkg::flit_t make_flit(logic [1:0] ft, logic [31:0] word);
    dma_pkg::flit_t f;
    f.ftype        = dma_pkg::flit_type_e'(ft);
    f.content.word = word;
    return f;
  endfunction

  // Header with random reserved bits
  function automatic logic [31:0] header_word(logic [1:0] ptype, logic last, logic [1:0] id);
    dma_pkg::resp_hdr_t h;
    h           = dma_pkg::resp_hdr_t'($urandom);
    h.pkt_type  = dma_pkg::pkt_type_e'(ptype);
    h.resp_last = last;
    h.id        = id;
    return h;
  endfunction

  task automatic push_done(logic [1:0] id, logic [31:0] end_addr);
    dma_pkg::done_rec_t d;
    d.valid    = 1'b1;
    d.id       = id;
    d.count    = dma_pkg::COUNT_W'(pending[id]);
    d.end_addr = end_addr;
    exp_done.push_back(d);
    pending[id] = 0;
  endtask

  // Single flit L2R that completes only with response-last
  task automatic add_l2r(logic [1:0] id, logic last);
    flits.push_back(make_flit(dma_pkg::FLIT_SINGLE, header_word(2'b01, last, id)));
    if (last) begin
      push_done(id, (pending[id] == 0) ? 32'h0 : model_addr);
    end
  endtask

  // Header, size, address, then 0 to 8 data flits
  task automatic add_r2l_packet(logic [1:0] id, logic last);
    logic [31:0]      addr;
    logic [31:0]      data;
    int unsigned      n;
    dma_pkg::bus_wr_t w;
    addr = $urandom;
    n    = $urandom % 9;
    flits.push_back(make_flit(dma_pkg::FLIT_NORMAL, header_word(2'b10, last, id)));
    flits.push_back(make_flit(dma_pkg::FLIT_NORMAL, n));
    flits.push_back(make_flit((n == 0) ? dma_pkg::FLIT_LAST : dma_pkg::FLIT_NORMAL, addr));
    for (int i = 0; i < n; i++) begin
      data = $urandom;
      flits.push_back(make_flit((i == n - 1) ? dma_pkg::FLIT_LAST : dma_pkg::FLIT_NORMAL, data));
      w.en   = 1'b1;
      w.addr = addr + i;
      w.data = data;
      exp_wr.push_back(w);
    end
    // Writer keeps the address past the last word
    pending[id] += n;
    model_addr = addr + n;
    if (last) begin
      push_done(id, model_addr);
    end
  endtask

  // Type 00 or 11 dropped up to its last flit
  task automatic add_unknown();
    int unsigned extra;
    extra = $urandom % 4;
    flits.push_back(make_flit((extra == 0) ? dma_pkg::FLIT_SINGLE : dma_pkg::FLIT_NORMAL,
                              header_word(($urandom % 2) ? 2'b11 : 2'b00,
                                          1'($urandom), 2'($urandom))));
    for (int i = 0; i < extra; i++) begin
      flits.push_back(make_flit((i == extra - 1) ? dma_pkg::FLIT_LAST : dma_pkg::FLIT_NORMAL,
                                $urandom));
    end
  endtask

  task automatic add_responses(int unsigned n_resp);
    logic [1:0]  id;
    int unsigned kind;
    int unsigned n_pkt;
    for (int r = 0; r < n_resp; r++) begin
      id   = 2'($urandom);
      kind = $urandom % 4;
      if (kind == 0) begin
        add_l2r(id, ($urandom % 4) != 0);
      end else if (kind == 1) begin
        add_unknown();
      end else begin
        // Multi-packet response with the last flag on the final one
        n_pkt = 1 + $urandom % 3;
        for (int p = 0; p < n_pkt; p++) begin
          add_r2l_packet(id, p == n_pkt - 1);
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Output checks
  ////////////////////////////////////////

  task automatic check_write();
    dma_pkg::bus_wr_t exp;
    assert (exp_wr.size() != 0) else begin
      $display("Bus write to %h appeared when no write was expected", bus_o.addr);
      abort_run();
    end
    exp = exp_wr.pop_front();
    assert (bus_o.addr == exp.addr) else begin
      $display("CHECK FAILED bus_o.addr got %h expected %h", bus_o.addr, exp.addr);
      abort_run();
    end
    assert (bus_o.data == exp.data) else begin
      $display("CHECK FAILED bus_o.data got %h expected %h", bus_o.data, exp.data);
      abort_run();
    end
  endtask

  task automatic check_done();
    dma_pkg::done_rec_t exp;
    assert (exp_done.size() != 0) else begin
      $display("Completion for id %h appeared when none was expected", done_o.id);
      abort_run();
    end
    exp = exp_done.pop_front();
    assert (done_o.id == exp.id) else begin
      $display("CHECK FAILED done_o.id got %h expected %h", done_o.id, exp.id);
      abort_run();
    end
    assert (done_o.count == exp.count) else begin
      $display("CHECK FAILED done_o.count got %h expected %h", done_o.count, exp.count);
      abort_run();
    end
    assert (done_o.end_addr == exp.end_addr) else begin
      $display("CHECK FAILED done_o.end_addr got %h expected %h",
               done_o.end_addr, exp.end_addr);
      abort_run();
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (bus_o.en) begin
        check_write();
      end
      if (done_o.valid) begin
        check_done();
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, outputs still missing", cycles);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int unsigned gap;
    void'($urandom(45986));
    rst         = 1'b1;
    noc_valid_i = 1'b0;
    noc_flit_i  = '0;
    cycles      = 0;
    model_addr  = '0;
    // Gapped phase, then back to back burst
    add_responses(24);
    burst_start = flits.size();
    add_responses(24);
    limit = 10 * flits.size() + 200;

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < flits.size(); i++) begin
      gap = (i < burst_start) ? $urandom % 4 : 0;
      if (gap != 0) begin
        noc_valid_i <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      noc_valid_i <= 1'b1;
      noc_flit_i  <= flits[i];
      @(posedge clk);
      // Hold the flit until the buffer takes it
      while (!noc_ready_o) @(posedge clk);
    end
    noc_valid_i <= 1'b0;

    while (exp_wr.size() != 0 || exp_done.size() != 0) @(posedge clk);
    // Catch any late extra output
    repeat (5) @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule
